// ==== all.f ====
+incdir+include
design/node_pkg.sv
design/node_addr_decode.sv
design/node_ram_arbiter.sv
design/node_spram.sv
design/node_resp_mux.sv
design/node_mem_top.sv
test/node_mem_assert.sv
test/tb_node_mem.sv

// ==== Bender.yml ====
package:
  name: node_mem

export_include_dirs:
  - include

sources:
  - files:
      - design/node_pkg.sv
      - design/node_addr_decode.sv
      - design/node_ram_arbiter.sv
      - design/node_spram.sv
      - design/node_resp_mux.sv
      - design/node_mem_top.sv
  - target: test
    files:
      - test/node_mem_assert.sv
      - test/tb_node_mem.sv

// ==== test/node_mem_stimulus.txt ====
# port: 0 core, 1 NIC, 2 both at once; op: 0 write, 1 read, 2 read expecting err
# columns in hex: port op sel addr wdata expect; port 2 uses random data at addr and addr+4
0 0 f 00000100 11223344 00000000
0 0 5 00000100 aabbccdd 00000000
0 1 f 00000100 00000000 11bb33dd
1 0 f 00000200 cafef00d 00000000
0 1 f 00000200 00000000 cafef00d
0 0 f 00000204 5a5aa5a5 00000000
1 1 f 00000204 00000000 5a5aa5a5
1 0 f 00000208 12345678 00000000
1 0 c 00000208 beef0000 00000000
0 1 f 00000208 00000000 beef5678
0 0 f 00040010 deadbeef 00000000
0 1 f 00040010 00000000 deadbeef
0 0 f 00000010 01020304 00000000
1 1 f 00040010 00000000 01020304
0 1 f 00040010 00000000 deadbeef
0 0 f 00047ffc 87654321 00000000
0 1 f 00047ffc 00000000 87654321
0 2 f 80000000 00000000 00000000
0 2 f 00050000 00000000 00000000
0 2 f fffffffc 00000000 00000000
2 0 f 00000300 00000000 00000000
2 0 f 00040300 00000000 00000000

// ==== test/tb_node_mem.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module tb_node_mem import node_pkg::*; ();

	localparam int TIMEOUT = 50; // Clocks allowed for any single response

	logic clk;
	logic rst_n_i;
	bus_req_t cpu_req;
	bus_req_t nic_req;
	bus_rsp_t cpu_rsp;
	bus_rsp_t nic_rsp;
	integer seed;

	node_mem_top UUT (.clk(clk), .rst_n_i(rst_n_i), .cpu_req_i(cpu_req), .nic_req_i(nic_req),
		.cpu_rsp_o(cpu_rsp), .nic_rsp_o(nic_rsp));

	always #50 clk = ~clk; // 100 ns period

	// ====================
	// Checks
	// ====================
	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1);
	endtask

	// Only the handshake bits are compared, data has its own check
	task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
		if (got.ack !== exp.ack || got.err !== exp.err)
			stop_on_error($sformatf("ERR %s ack %h err %h expected ack %h err %h",
				name, got.ack, got.err, exp.ack, exp.err));
	endtask

	task automatic check_data(input string name, input logic [`NODE_DW-1:0] got,
		input logic [`NODE_DW-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	// ====================
	// Bus driver
	// ====================
	function automatic bus_req_t make_req(input logic we, input logic [`NODE_SELW-1:0] sel,
		input logic [`NODE_AW-1:0] adr, input logic [`NODE_DW-1:0] dat);
		bus_req_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we = we;
		r.sel = sel;
		r.adr = adr;
		r.dat = dat;
		return r;
	endfunction

	task automatic drive_port(input bit nic, input bus_req_t req);
		if (nic)
			nic_req = req;
		else
			cpu_req = req;
	endtask

	// One bus cycle, request held until ack or err, then stb drops at once
	task automatic bus_access(input bit nic, input bus_req_t req, output bus_rsp_t rsp);
		int waited;
		bus_rsp_t cur;
		@(negedge clk);
		drive_port(nic, req);
		waited = 0;
		cur = '0;
		while (cur.ack !== 1'b1 && cur.err !== 1'b1) begin
			@(negedge clk); // Outputs are settled half a period after the edge
			cur = nic ? nic_rsp : cpu_rsp;
			waited++;
			if (waited > TIMEOUT)
				stop_on_error($sformatf("Timeout, the %s port got no ack or err",
					nic ? "NIC" : "core"));
		end
		rsp = cur;
		drive_port(nic, '0);
	endtask

	// ====================
	// Transactions
	// ====================
	task automatic run_single(input int port, input int op, input logic [`NODE_SELW-1:0] sel,
		input logic [`NODE_AW-1:0] adr, input logic [`NODE_DW-1:0] wdat,
		input logic [`NODE_DW-1:0] exp_dat);
		bus_rsp_t rsp;
		bus_rsp_t exp_rsp;
		string name;
		bus_access(port == 1, make_req(op == 0, sel, adr, wdat), rsp);
		exp_rsp = '0;
		exp_rsp.ack = (op != 2); // Unmapped addresses give err and never ack
		exp_rsp.err = (op == 2);
		if (port == 1)
			name = "nic_rsp_o";
		else
			name = "cpu_rsp_o";
		check_rsp(name, rsp, exp_rsp);
		if (op == 1)
			check_data({name, ".dat"}, rsp.dat, exp_dat);
	endtask

	// Both ports start in the same cycle, first writing and then reading back
	task automatic run_pair(input logic [`NODE_AW-1:0] adr);
		logic [`NODE_DW-1:0] cpu_dat;
		logic [`NODE_DW-1:0] nic_dat;
		bus_rsp_t cpu_got;
		bus_rsp_t nic_got;
		bus_rsp_t exp_rsp;
		cpu_dat = $random(seed);
		nic_dat = $random(seed);
		exp_rsp = '0;
		exp_rsp.ack = 1'b1;
		fork
			bus_access(1'b0, make_req(1'b1, '1, adr, cpu_dat), cpu_got);
			bus_access(1'b1, make_req(1'b1, '1, adr + 4, nic_dat), nic_got);
		join
		check_rsp("cpu_rsp_o", cpu_got, exp_rsp);
		check_rsp("nic_rsp_o", nic_got, exp_rsp);
		fork
			bus_access(1'b0, make_req(1'b0, '1, adr, '0), cpu_got);
			bus_access(1'b1, make_req(1'b0, '1, adr + 4, '0), nic_got);
		join
		check_rsp("cpu_rsp_o", cpu_got, exp_rsp);
		check_rsp("nic_rsp_o", nic_got, exp_rsp);
		check_data("cpu_rsp_o.dat", cpu_got.dat, cpu_dat);
		check_data("nic_rsp_o.dat", nic_got.dat, nic_dat);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int fd;
		int rc;
		int n;
		int count;
		int port;
		int op;
		logic [`NODE_SELW-1:0] sel;
		logic [`NODE_AW-1:0] adr;
		logic [`NODE_DW-1:0] wdat;
		logic [`NODE_DW-1:0] exp_dat;
		string line;
		bus_rsp_t idle_rsp;
		clk = 1'b0;
		rst_n_i = 1'b0;
		cpu_req = '0;
		nic_req = '0;
		seed = 10928;
		count = 0;
		idle_rsp = '0;
		repeat (8) @(negedge clk);
		rst_n_i = 1'b1;
		repeat (2) @(negedge clk);
		check_rsp("cpu_rsp_o", cpu_rsp, idle_rsp); // Both ports quiet after reset
		check_rsp("nic_rsp_o", nic_rsp, idle_rsp);
		fd = $fopen("test/node_mem_stimulus.txt", "r");
		if (fd == 0)
			stop_on_error("Could not open test/node_mem_stimulus.txt");
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			n = $sscanf(line, "%h %h %h %h %h %h", port, op, sel, adr, wdat, exp_dat);
			if (rc > 0 && n == 6) begin // Comment and blank lines do not parse
				if (port == 2)
					run_pair(adr);
				else
					run_single(port, op, sel, adr, wdat, exp_dat);
				count++;
			end
		end
		$fclose(fd);
		if (count == 0)
			stop_on_error("The stimulus file held no transactions");
		repeat (4) @(negedge clk);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== test/node_mem_assert.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module node_mem_assert import node_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input bus_rsp_t cpu_rsp_i,
	input bus_rsp_t nic_rsp_i,
	input logic ram_cpu_ack_i // Core side ack straight out of the arbiter
);

	// ====================
	// Response shape
	// ====================
	cpu_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(cpu_rsp_i.ack && cpu_rsp_i.err)) else $error("Core port shows ack and err together");

	// Each response lasts exactly one clock
	cpu_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		(cpu_rsp_i.ack || cpu_rsp_i.err) |=> !(cpu_rsp_i.ack || cpu_rsp_i.err))
		else $error("Core response is wider than one cycle");
	nic_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		nic_rsp_i.ack |=> !nic_rsp_i.ack) else $error("NIC ack is wider than one cycle");

	// Nothing answers while the node is held in reset
	quiet_in_reset: assert property (@(posedge clk) !rst_n_i |->
		!(cpu_rsp_i.ack || cpu_rsp_i.err || nic_rsp_i.ack || nic_rsp_i.err))
		else $error("Response seen while reset is low");

	// The main RAM serves one port per access
	one_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(ram_cpu_ack_i && nic_rsp_i.ack)) else $error("Arbiter acknowledged both ports");

endmodule

bind node_mem_top node_mem_assert u_assert (.clk(clk), .rst_n_i(rst_n_i),
	.cpu_rsp_i(cpu_rsp_o), .nic_rsp_i(nic_rsp_o), .ram_cpu_ack_i(ram_cpu_rsp.ack));

// ==== design/node_mem_top.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module node_mem_top import node_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input bus_req_t cpu_req_i,
	input bus_req_t nic_req_i,
	output bus_rsp_t cpu_rsp_o,
	output bus_rsp_t nic_rsp_o
);

	dec_req_t dec; // Decoded core item, one per bus cycle
	bus_rsp_t ram_cpu_rsp; // Core side of the main RAM
	bus_rsp_t spram_rsp;

	// ====================
	// Decode stage
	// ====================
	node_addr_decode u_decode (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.cpu_req_i (cpu_req_i),
		.dec_o (dec)
	);

	// ====================
	// Memory stage
	// ====================

	// The NIC bypasses decode and sees only main RAM
	node_ram_arbiter u_ram (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.dec_i (dec),
		.nic_req_i (nic_req_i),
		.cpu_rsp_o (ram_cpu_rsp),
		.nic_rsp_o (nic_rsp_o)
	);

	node_spram u_spram (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.dec_i (dec),
		.rsp_o (spram_rsp)
	);

	// Response stage, also produces the bus error
	node_resp_mux u_resp (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.dec_i (dec),
		.ram_rsp_i (ram_cpu_rsp),
		.spram_rsp_i (spram_rsp),
		.cpu_rsp_o (cpu_rsp_o)
	);

endmodule

// ==== design/node_resp_mux.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module node_resp_mux import node_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input dec_req_t dec_i,
	input bus_rsp_t ram_rsp_i,
	input bus_rsp_t spram_rsp_i,
	output bus_rsp_t cpu_rsp_o
);

	logic err_q; // Bus error pulse for unmapped addresses

	// ====================
	// Unmapped region
	// ====================

	// One clock after the item, so two after the request
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			err_q <= 1'b0;
		else
			err_q <= dec_i.valid & (dec_i.region == REGION_EXT);
	end

	// ====================
	// Merge
	// ====================

	// Only one source answers a given core cycle
	always_comb begin
		cpu_rsp_o.ack = ram_rsp_i.ack | spram_rsp_i.ack;
		cpu_rsp_o.err = err_q | ram_rsp_i.err | spram_rsp_i.err;
		// Take the data of the source that acknowledges
		if (spram_rsp_i.ack)
			cpu_rsp_o.dat = spram_rsp_i.dat;
		else
			cpu_rsp_o.dat = ram_rsp_i.dat;
	end

endmodule

// ==== design/node_spram.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module node_spram import node_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input dec_req_t dec_i,
	output bus_rsp_t rsp_o
);

	localparam int DEPTH = 1 << `NODE_SPRAM_AW;
	localparam int LAT = `NODE_RD_LAT;

	// Private scratchpad of the core
	logic [`NODE_DW-1:0] mem [DEPTH];

	logic hit; // Scratchpad item this cycle
	logic [`NODE_SPRAM_AW-1:0] word_adr;
	logic [LAT-1:0] ack_sr; // Acknowledge generator, one bit per read stage
	logic [`NODE_DW-1:0] dat_sr [LAT]; // Read data follows the ack bits

	assign hit = dec_i.valid & (dec_i.region == REGION_SPRAM);
	assign word_adr = dec_i.req.adr[`NODE_SPRAM_AW+1:2];

	// ====================
	// Acknowledge generator
	// ====================

	// Every item is acknowledged, write or read
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_sr <= '0;
		else
			ack_sr <= {ack_sr[LAT-2:0], hit};
	end

	// Read first, the old word goes out even on a write
	always_ff @(posedge clk) begin
		if (hit) begin
			dat_sr[0] <= mem[word_adr];
			for (int i = 0; i < `NODE_SELW; i++) begin
				if (dec_i.req.we && dec_i.req.sel[i])
					mem[word_adr][i*8 +: 8] <= dec_i.req.dat[i*8 +: 8];
			end
		end
		for (int j = 1; j < LAT; j++)
			dat_sr[j] <= dat_sr[j-1]; // Delay to line up with the ack
	end

	// The scratchpad never flags an error
	always_comb begin
		rsp_o.ack = ack_sr[LAT-1];
		rsp_o.err = 1'b0;
		rsp_o.dat = dat_sr[LAT-1];
	end

endmodule

// ==== design/node_ram_arbiter.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module node_ram_arbiter import node_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input dec_req_t dec_i,
	input bus_req_t nic_req_i,
	output bus_rsp_t cpu_rsp_o,
	output bus_rsp_t nic_rsp_o
);

	localparam int DEPTH = 1 << `NODE_RAM_AW;

	// Shared main RAM, one word per entry
	logic [`NODE_DW-1:0] mem [DEPTH];

	arb_state_e state_q;
	arb_state_e state_d;

	logic cpu_pend_q; // Core RAM item waiting while the NIC owns the RAM
	logic nic_hold_q; // NIC already answered, wait for it to drop stb
	logic last_nic_q; // The NIC was the last one served
	logic cpu_want;
	logic nic_want;
	logic pick_cpu;
	logic pick_nic;
	logic go; // A grant starts this cycle and the RAM is accessed
	bus_req_t sel_req; // Request of the side being granted
	logic [`NODE_RAM_AW-1:0] word_adr;
	logic [`NODE_DW-1:0] rd_q; // First read stage, straight out of the array
	logic [`NODE_DW-1:0] dat_q; // Second read stage, returned with ack
	logic ack_cpu_q;
	logic ack_nic_q;

	// ====================
	// Request selection
	// ====================

	// The core item is a one clock pulse, so it is also kept in cpu_pend_q
	assign cpu_want = cpu_pend_q | (dec_i.valid & (dec_i.region == REGION_RAM));
	assign nic_want = nic_req_i.cyc & nic_req_i.stb & ~nic_hold_q;

	// When both wait the side that was not served last wins
	assign pick_nic = nic_want & (~cpu_want | ~last_nic_q);
	assign pick_cpu = cpu_want & ~pick_nic;
	assign go = (state_q == ARB_IDLE) & (pick_nic | pick_cpu);

	assign sel_req = pick_nic ? nic_req_i : dec_i.req; // Both hold their request steady
	assign word_adr = sel_req.adr[`NODE_RAM_AW+1:2]; // Drop the byte offset

	// Next owner of the RAM
	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (pick_nic)
					state_d = ARB_NIC;
				else if (pick_cpu)
					state_d = ARB_CPU;
			end
			// The grant lasts for the two read stages, then the RAM is free again
			ARB_CPU, ARB_NIC: state_d = ARB_IDLE;
			default: state_d = ARB_IDLE;
		endcase
	end

	// ====================
	// Control registers
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ARB_IDLE;
			cpu_pend_q <= 1'b0;
			nic_hold_q <= 1'b0;
			last_nic_q <= 1'b0;
			ack_cpu_q <= 1'b0;
			ack_nic_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Keep the core item until it is granted
			cpu_pend_q <= cpu_want & ~(go & pick_cpu);
			// Ack goes out as the grant ends, then the NIC must release stb
			nic_hold_q <= (state_q == ARB_NIC) | (nic_hold_q & nic_req_i.stb);
			if (go)
				last_nic_q <= pick_nic;
			// Reads and writes alike are acknowledged at the end of the grant
			ack_cpu_q <= (state_q == ARB_CPU);
			ack_nic_q <= (state_q == ARB_NIC);
		end
	end

	// ====================
	// RAM array
	// ====================

	// Read first, so a write returns the old word
	always_ff @(posedge clk) begin
		if (go) begin
			rd_q <= mem[word_adr];
			for (int i = 0; i < `NODE_SELW; i++) begin
				if (sel_req.we && sel_req.sel[i])
					mem[word_adr][i*8 +: 8] <= sel_req.dat[i*8 +: 8]; // One lane per sel bit
			end
		end
		dat_q <= rd_q; // Output register of the read pipeline
	end

	// Both sides see the same data, only the granted one gets ack
	always_comb begin
		cpu_rsp_o.ack = ack_cpu_q;
		cpu_rsp_o.err = 1'b0;
		cpu_rsp_o.dat = dat_q;
		nic_rsp_o.ack = ack_nic_q;
		nic_rsp_o.err = 1'b0;
		nic_rsp_o.dat = dat_q;
	end

endmodule

// ==== design/node_addr_decode.sv ====
`timescale 1ns/1ps
`include "node_settings.svh"

module node_addr_decode import node_pkg::*; (
	input logic clk,
	input logic rst_n_i,
	input bus_req_t cpu_req_i,
	output dec_req_t dec_o
);

	// ====================
	// Region compare
	// ====================

	// Upper bits that pick main RAM, all must be zero
	localparam int RAM_LSB = `NODE_AW - `NODE_RAM_TOP_BITS;
	// Lowest address bit above the scratchpad word address and byte offset
	localparam int SPRAM_LSB = `NODE_SPRAM_AW + 2;

	logic take; // A fresh request is seen this cycle
	logic busy_q; // Set while the current request is still held by the core
	logic valid_q;
	region_e region_q;
	region_e region_d;
	bus_req_t req_q; // Captured request, kept stable for the later stages

	// Classify the live address, only used in the cycle the request is taken
	always_comb begin
		if (cpu_req_i.adr[`NODE_AW-1:RAM_LSB] == '0)
			region_d = REGION_RAM;
		else if (cpu_req_i.adr[`NODE_AW-1:SPRAM_LSB] == (`NODE_AW-SPRAM_LSB)'(`NODE_SPRAM_BASE))
			region_d = REGION_SPRAM;
		else
			region_d = REGION_EXT;
	end

	// Only one item per bus cycle, so a held strobe is ignored after the first clock
	assign take = cpu_req_i.cyc & cpu_req_i.stb & ~busy_q;

	// ====================
	// Control registers
	// ====================
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			valid_q <= 1'b0;
			region_q <= REGION_RAM;
		end else begin
			valid_q <= take; // Single clock pulse per request
			// Stay busy until the core drops its strobe after the response
			busy_q <= take | (busy_q & cpu_req_i.stb);
			if (take)
				region_q <= region_d;
		end
	end

	// Payload register, only loaded when a request is taken
	always_ff @(posedge clk) begin
		if (take)
			req_q <= cpu_req_i;
	end

	// Assemble the item for the memory stages
	always_comb begin
		dec_o.valid = valid_q;
		dec_o.region = region_q;
		dec_o.req = req_q;
	end

endmodule

// ==== design/node_pkg.sv ====
`include "node_settings.svh"

package node_pkg;

	// ====================
	// Enums
	// ====================

	// Target of a decoded core request
	typedef enum logic [1:0] {
		REGION_RAM, // Shared main RAM
		REGION_SPRAM, // Private scratchpad
		REGION_EXT // Anything else answers with a bus error
	} region_e;

	// Owner of the main RAM port
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CPU,
		ARB_NIC
	} arb_state_e;

	// ====================
	// Bus structs
	// ====================

	// Request from a master, held steady until ack or err
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`NODE_SELW-1:0] sel; // Byte lanes, bit 0 is dat[7:0]
		logic [`NODE_AW-1:0] adr;
		logic [`NODE_DW-1:0] dat; // Write data
	} bus_req_t;

	// Response to a master, ack and err are single cycle pulses
	typedef struct packed {
		logic ack;
		logic err;
		logic [`NODE_DW-1:0] dat; // Read data, only meaningful with ack
	} bus_rsp_t;

	// One item per core bus cycle, valid is high for a single clock
	typedef struct packed {
		logic valid;
		region_e region;
		bus_req_t req;
	} dec_req_t;

endpackage

// ==== include/node_settings.svh ====
`ifndef NODE_SETTINGS_SVH
`define NODE_SETTINGS_SVH

// ====================
// Bus widths
// ====================
`define NODE_DW 32 // Data width of both bus ports
`define NODE_AW 32 // Byte address width
`define NODE_SELW 4 // One select bit per byte lane

// ====================
// Memory sizes and address map
// ====================
`define NODE_RAM_AW 15 // Main RAM word address, 32K words or 128 KB
`define NODE_SPRAM_AW 13 // Scratchpad word address, 8K words or 32 KB

// Bits 31 to 18 must all be zero for a main RAM access
`define NODE_RAM_TOP_BITS 14
// Bits 31 to 15 equal to this value select the scratchpad at 0x40000
`define NODE_SPRAM_BASE 8

// Read latency of both RAMs in clocks
`define NODE_RD_LAT 2

`endif
